// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_exec_slice
FILELIST ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) cpu_defines.svh

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

// ==== alu.sv ====
`timescale 1ns/10ps
`include "cpu_defines.svh"

module alu
	import cpu_pkg::*;
(
	input  alu_op_e				i_op,
	input  logic [`CPU_REG_WIDTH-1:0]	i_a,
	input  logic [`CPU_REG_WIDTH-1:0]	i_b,
	output logic [`CPU_REG_WIDTH-1:0]	o_result,
	output logic				o_ovf
);

	localparam int MSB = `CPU_REG_WIDTH - 1;

	logic [`CPU_REG_WIDTH-1:0]	sum;
	logic [`CPU_REG_WIDTH-1:0]	diff;
	logic				lt_signed;

	assign sum = i_a + i_b;
	assign diff = i_a - i_b;
	// Sign of the true difference, corrected when the subtraction overflows
	assign lt_signed = (i_a[MSB] != i_b[MSB]) ? i_a[MSB] : diff[MSB];

	always_comb
	begin
		o_result = '0;
		o_ovf = 1'b0;
		case (i_op)
		ALU_ADD:
		begin
			o_result = sum;
			o_ovf = (i_a[MSB] == i_b[MSB]) && (sum[MSB] != i_a[MSB]);	// Same signs in, other sign out
		end
		ALU_SUB:
		begin
			o_result = diff;
			o_ovf = (i_a[MSB] != i_b[MSB]) && (diff[MSB] != i_a[MSB]);
		end
		ALU_AND: o_result = i_a & i_b;
		ALU_OR: o_result = i_a | i_b;
		ALU_XOR: o_result = i_a ^ i_b;
		ALU_SLT: o_result = {{MSB{1'b0}}, lt_signed};
		ALU_SLTU: o_result = {{MSB{1'b0}}, (i_a < i_b)};
		ALU_LUI: o_result = {i_b[15:0], 16'h0000};	// Immediate moves to the upper half
		default: o_result = '0;
		endcase
	end

endmodule

// ==== cpu_defines.svh ====
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Width of a general purpose register and of the ALU datapath
`define CPU_REG_WIDTH 32

// Instruction and data addresses share one width
`define CPU_ADDR_WIDTH 32

// Register numbers select one of 32 registers
`define CPU_REGNO_WIDTH 5

`endif

// ==== cpu_pkg.sv ====
`include "cpu_defines.svh"

package cpu_pkg;

	// Primary opcode field, bits 31:26
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00, OP_REGIMM = 6'h01, OP_J = 6'h02, OP_JAL = 6'h03,
		OP_BEQ = 6'h04, OP_BNE = 6'h05, OP_ADDI = 6'h08, OP_ADDIU = 6'h09,
		OP_ORI = 6'h0d, OP_LUI = 6'h0f, OP_LW = 6'h23, OP_SW = 6'h2b
	} opcode_e;

	// Function field of SPECIAL instructions, bits 5:0
	typedef enum logic [5:0] {
		FN_JR = 6'h08, FN_SYSCALL = 6'h0c, FN_BREAK = 6'h0d,
		FN_ADD = 6'h20, FN_ADDU = 6'h21, FN_SUB = 6'h22, FN_SUBU = 6'h23,
		FN_AND = 6'h24, FN_OR = 6'h25, FN_XOR = 6'h26, FN_SLT = 6'h2a, FN_SLTU = 6'h2b
	} funct_e;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLTU, ALU_LUI
	} alu_op_e;

	typedef enum logic [1:0] {SRC_RS_RT, SRC_RS_IMM, SRC_PC_IMM} alu_src_e;

	typedef enum logic [2:0] {
		JUMP_NONE, JUMP_J, JUMP_JR, JUMP_BEQ, JUMP_BNE, JUMP_BLTZ, JUMP_BGEZ
	} jump_e;

	typedef enum logic [1:0] {LSU_IDLE, LSU_LOAD, LSU_STORE} lsu_op_e;

	typedef enum logic [1:0] {TRAP_NONE, TRAP_SYSCALL, TRAP_BREAK} sw_trap_e;

	typedef struct packed {
		logic [`CPU_REGNO_WIDTH-1:0]	rd_no;		// Zero means no writeback
		logic [`CPU_REG_WIDTH-1:0]	rs_val;
		logic [`CPU_REG_WIDTH-1:0]	rt_val;
		logic [`CPU_REG_WIDTH-1:0]	imm;		// Already extended and shifted
		logic [`CPU_ADDR_WIDTH-1:0]	pc_p1;		// Base of PC relative branches
		alu_op_e			alu_op;
		alu_src_e			alu_src;
		logic				ovf_en;		// Trap on signed overflow
		jump_e				jump;
		logic				link;		// Write return address to rd
		lsu_op_e			lsu_op;
		sw_trap_e			sw_trap;
	} decoded_t;

	typedef struct packed {
		logic				en;
		logic [`CPU_REGNO_WIDTH-1:0]	rd_no;
		logic [`CPU_REG_WIDTH-1:0]	data;
	} wb_t;

	typedef struct packed {
		logic				valid;
		logic [`CPU_ADDR_WIDTH-1:0]	addr;
	} jump_t;

	typedef struct packed {
		lsu_op_e			op;
		logic [`CPU_ADDR_WIDTH-1:0]	addr;
		logic [`CPU_REG_WIDTH-1:0]	data;
	} mem_req_t;

	typedef struct packed {
		logic	overflow;
		logic	addr_error;
		logic	syscall;
		logic	brk;
	} exc_t;

endpackage

// ==== decoder.sv ====
`timescale 1ns/10ps
`include "cpu_defines.svh"

module decoder
	import cpu_pkg::*;
(
	input  logic [31:0]			i_instr,
	input  logic [`CPU_ADDR_WIDTH-1:0]	i_pc_p1,
	input  logic [`CPU_REG_WIDTH-1:0]	i_rs_val,
	input  logic [`CPU_REG_WIDTH-1:0]	i_rt_val,
	output logic [`CPU_REGNO_WIDTH-1:0]	o_rs_no,
	output logic [`CPU_REGNO_WIDTH-1:0]	o_rt_no,
	output decoded_t			o_dec
);

	logic [5:0]			opcode;
	logic [5:0]			funct;
	logic [`CPU_REGNO_WIDTH-1:0]	rd_f;
	logic [`CPU_REG_WIDTH-1:0]	imm_sext;	// Arithmetic and address offsets
	logic [`CPU_REG_WIDTH-1:0]	imm_zext;	// Logic ops and LUI
	logic [`CPU_REG_WIDTH-1:0]	branch_off;	// Word offset turned into bytes
	logic [`CPU_REG_WIDTH-1:0]	jump_abs;	// J target inside the current 256 MB region

	assign opcode = i_instr[31:26];
	assign funct = i_instr[5:0];
	assign o_rs_no = i_instr[25:21];
	assign o_rt_no = i_instr[20:16];
	assign rd_f = i_instr[15:11];
	assign imm_sext = {{16{i_instr[15]}}, i_instr[15:0]};
	assign imm_zext = {16'h0000, i_instr[15:0]};
	assign branch_off = {imm_sext[29:0], 2'b00};
	assign jump_abs = {i_pc_p1[31:28], i_instr[25:0], 2'b00};

	always_comb
	begin
		// Defaults describe a no-op that writes nothing
		o_dec.rd_no = '0;
		o_dec.rs_val = i_rs_val;
		o_dec.rt_val = i_rt_val;
		o_dec.imm = imm_sext;
		o_dec.pc_p1 = i_pc_p1;
		o_dec.alu_op = ALU_ADD;
		o_dec.alu_src = SRC_RS_IMM;
		o_dec.ovf_en = 1'b0;
		o_dec.jump = JUMP_NONE;
		o_dec.link = 1'b0;
		o_dec.lsu_op = LSU_IDLE;
		o_dec.sw_trap = TRAP_NONE;
		case (opcode)
		OP_SPECIAL:
		begin
			o_dec.alu_src = SRC_RS_RT;
			o_dec.rd_no = rd_f;	// Cleared again below for non-ALU functions
			case (funct)
			FN_ADDU: o_dec.alu_op = ALU_ADD;
			FN_ADD: o_dec.ovf_en = 1'b1;
			FN_SUBU: o_dec.alu_op = ALU_SUB;
			FN_SUB:
			begin
				o_dec.alu_op = ALU_SUB;
				o_dec.ovf_en = 1'b1;
			end
			FN_AND: o_dec.alu_op = ALU_AND;
			FN_OR: o_dec.alu_op = ALU_OR;
			FN_XOR: o_dec.alu_op = ALU_XOR;
			FN_SLT: o_dec.alu_op = ALU_SLT;
			FN_SLTU: o_dec.alu_op = ALU_SLTU;
			FN_JR:
			begin
				o_dec.rd_no = '0;
				o_dec.alu_src = SRC_RS_IMM;	// Target is rs plus zero
				o_dec.imm = '0;
				o_dec.jump = JUMP_JR;
			end
			FN_SYSCALL:
			begin
				o_dec.rd_no = '0;
				o_dec.sw_trap = TRAP_SYSCALL;
			end
			FN_BREAK:
			begin
				o_dec.rd_no = '0;
				o_dec.sw_trap = TRAP_BREAK;
			end
			default: o_dec.rd_no = '0;	// Unknown function is a no-op
			endcase
		end
		OP_REGIMM:
		begin
			// Only rt 0 and 1 are branches, other REGIMM forms are no-ops
			o_dec.alu_src = SRC_PC_IMM;
			o_dec.imm = branch_off;
			if (o_rt_no == 5'd0)
				o_dec.jump = JUMP_BLTZ;
			else if (o_rt_no == 5'd1)
				o_dec.jump = JUMP_BGEZ;
		end
		OP_J, OP_JAL:
		begin
			o_dec.rs_val = '0;	// OR with zero passes the absolute target through
			o_dec.imm = jump_abs;
			o_dec.alu_op = ALU_OR;
			o_dec.jump = JUMP_J;
			o_dec.link = (opcode == OP_JAL);
			o_dec.rd_no = (opcode == OP_JAL) ? 5'd31 : 5'd0;	// Link register for JAL
		end
		OP_BEQ, OP_BNE:
		begin
			o_dec.alu_src = SRC_PC_IMM;
			o_dec.imm = branch_off;
			o_dec.jump = (opcode == OP_BEQ) ? JUMP_BEQ : JUMP_BNE;
		end
		OP_ADDI, OP_ADDIU:
		begin
			o_dec.rd_no = o_rt_no;
			o_dec.ovf_en = (opcode == OP_ADDI);	// ADDIU never traps
		end
		OP_ORI, OP_LUI:
		begin
			o_dec.rd_no = o_rt_no;
			o_dec.imm = imm_zext;
			o_dec.alu_op = (opcode == OP_ORI) ? ALU_OR : ALU_LUI;
		end
		OP_LW: o_dec.lsu_op = LSU_LOAD;	// Address is rs plus offset, data comes later
		OP_SW: o_dec.lsu_op = LSU_STORE;
		default: o_dec.rd_no = '0;
		endcase
	end

endmodule

// ==== exec_slice_top.sv ====
`timescale 1ns/10ps
`include "cpu_defines.svh"

module exec_slice_top
	import cpu_pkg::*;
(
	input  logic				clk,
	input  logic				nrst,
	input  logic [31:0]			i_instr,
	input  logic [`CPU_ADDR_WIDTH-1:0]	i_pc_p0,
	input  logic [`CPU_ADDR_WIDTH-1:0]	i_pc_p1,
	input  logic				i_stall,
	input  logic				i_nullify,
	output wb_t				o_wb,
	output jump_t				o_jump,
	output mem_req_t			o_mem,
	output exc_t				o_exc
);

	logic [`CPU_REGNO_WIDTH-1:0]	rs_no;
	logic [`CPU_REGNO_WIDTH-1:0]	rt_no;
	logic [`CPU_REG_WIDTH-1:0]	rs_val;
	logic [`CPU_REG_WIDTH-1:0]	rt_val;
	decoded_t			dec;	// Decode result feeding the pipeline register

	decoder u_decoder (
		.i_instr	(i_instr),
		.i_pc_p1	(i_pc_p1),
		.i_rs_val	(rs_val),
		.i_rt_val	(rt_val),
		.o_rs_no	(rs_no),
		.o_rt_no	(rt_no),
		.o_dec		(dec)
	);

	execute_stage u_execute_stage (
		.clk		(clk),
		.nrst		(nrst),
		.i_stall	(i_stall),
		.i_nullify	(i_nullify),
		.i_pc_p0	(i_pc_p0),
		.i_dec		(dec),
		.o_wb		(o_wb),
		.o_jump		(o_jump),
		.o_mem		(o_mem),
		.o_exc		(o_exc)
	);

	// Writeback loops back here so the next instruction sees it through the bypass
	regfile u_regfile (
		.clk		(clk),
		.nrst		(nrst),
		.i_rs_no	(rs_no),
		.i_rt_no	(rt_no),
		.i_wb		(o_wb),
		.o_rs_val	(rs_val),
		.o_rt_val	(rt_val)
	);

endmodule

// ==== exec_vectors.txt ====
// instr pc_p0 pc_p1 stall nullify | wb_en wb_rd wb_data | jump_valid jump_addr
// | mem_op mem_addr mem_data | exc, all hex, expected columns belong to the previous line
// ALU writeback with bypass to the next instruction
24010005 100 104 0 0 0 00 00000000 0 00000000 0 00000000 00000000 0
2422fffd 104 108 0 0 1 01 00000005 0 00000000 0 00000000 00000000 0
00221821 108 10c 0 0 1 02 00000002 0 00000000 0 00000000 00000000 0
00412023 10c 110 0 0 1 03 00000007 0 00000000 0 00000000 00000000 0
00642824 110 114 0 0 1 04 fffffffd 0 00000000 0 00000000 00000000 0
00643025 114 118 0 0 1 05 00000005 0 00000000 0 00000000 00000000 0
00643826 118 11c 0 0 1 06 ffffffff 0 00000000 0 00000000 00000000 0
0081402a 11c 120 0 0 1 07 fffffffa 0 00000000 0 00000000 00000000 0
0081482b 120 124 0 0 1 08 00000001 0 00000000 0 00000000 00000000 0
3c0a7fff 124 128 0 0 1 09 00000000 0 00000000 0 00000000 00000000 0
354affff 128 12c 0 0 1 0a 7fff0000 0 00000000 0 00000000 00000000 0
01415820 12c 130 0 0 1 0a 7fffffff 0 00000000 0 00000000 00000000 0
202c0010 130 134 0 0 1 0b 80000004 0 00000000 0 00000000 00000000 8
00816822 134 138 0 0 1 0c 00000015 0 00000000 0 00000000 00000000 0
// Branches and jumps
10210004 138 13c 0 0 1 0d fffffff8 0 00000000 0 00000000 00000000 0
14210004 13c 140 0 0 0 00 00000000 1 0000014c 0 00000000 00000000 0
0480fffe 140 144 0 0 0 00 00000000 0 00000000 0 00000000 00000000 0
04810008 144 148 0 0 0 00 00000000 1 0000013c 0 00000000 00000000 0
04210008 148 14c 0 0 0 00 00000000 0 00000000 0 00000000 00000000 0
04200001 14c 150 0 0 0 00 00000000 1 0000016c 0 00000000 00000000 0
14220003 150 154 0 0 0 00 00000000 0 00000000 0 00000000 00000000 0
10220003 154 158 0 0 0 00 00000000 1 00000160 0 00000000 00000000 0
0c000100 158 15c 0 0 0 00 00000000 0 00000000 0 00000000 00000000 0
03e07021 15c 160 0 0 1 1f 00000158 1 00000400 0 00000000 00000000 0
00400008 160 164 0 0 1 0e 00000158 0 00000000 0 00000000 00000000 0
08000080 164 168 0 0 0 00 00000000 1 00000002 0 00000000 00000000 4
// Memory requests and traps
8c2f0003 168 16c 0 0 0 00 00000000 1 00000200 0 00000000 00000000 0
aca6000b 16c 170 0 0 0 00 00000000 0 00000000 1 00000008 00000000 0
0000000c 170 174 0 0 0 00 00000000 0 00000000 2 00000010 ffffffff 0
0000000d 174 178 0 0 0 00 00000000 0 00000000 0 00000000 00000000 2
// Stall and nullify
24100033 178 17c 0 0 0 00 00000000 0 00000000 0 00000000 00000000 1
26110001 17c 180 1 0 0 00 00000000 0 00000000 0 00000000 00000000 0
26110001 180 184 0 0 1 10 00000033 0 00000000 0 00000000 00000000 0
ac310003 184 188 0 0 1 11 00000034 0 00000000 0 00000000 00000000 0
0000000c 188 18c 1 0 0 00 00000000 0 00000000 2 00000008 00000034 0
0000000c 18c 190 0 1 0 00 00000000 0 00000000 2 00000008 00000034 0
24120077 190 194 0 1 0 00 00000000 0 00000000 0 00000000 00000000 0
02409821 194 198 0 0 0 00 00000000 0 00000000 0 00000000 00000000 0
00000000 198 19c 0 0 1 13 00000000 0 00000000 0 00000000 00000000 0

// ==== execute_stage.sv ====
`timescale 1ns/10ps
`include "cpu_defines.svh"

module execute_stage
	import cpu_pkg::*;
(
	input  logic				clk,
	input  logic				nrst,
	input  logic				i_stall,
	input  logic				i_nullify,
	input  logic [`CPU_ADDR_WIDTH-1:0]	i_pc_p0,
	input  decoded_t			i_dec,
	output wb_t				o_wb,
	output jump_t				o_jump,
	output mem_req_t			o_mem,
	output exc_t				o_exc
);

	// Operand side, loaded on every unstalled edge
	alu_op_e			alu_op_r;
	logic [`CPU_REG_WIDTH-1:0]	alu_a_r;
	logic [`CPU_REG_WIDTH-1:0]	alu_b_r;
	logic [`CPU_REG_WIDTH-1:0]	store_data_r;
	logic [`CPU_ADDR_WIDTH-1:0]	link_pc_r;	// Return address for JAL

	// Control side, cleared to a bubble by reset or nullify
	logic [`CPU_REGNO_WIDTH-1:0]	rd_no_r;
	logic				ovf_en_r;
	logic				is_jump_r;
	logic				taken_r;
	logic				link_r;
	lsu_op_e			lsu_op_r;
	sw_trap_e			sw_trap_r;

	logic				branch_cond;
	logic [`CPU_REG_WIDTH-1:0]	alu_result;
	logic				alu_ovf;
	logic [`CPU_REGNO_WIDTH-1:0]	wb_rd_no;

	// Branch outcome is resolved from the register values before they are captured
	always_comb
	begin
		case (i_dec.jump)
		JUMP_J, JUMP_JR: branch_cond = 1'b1;
		JUMP_BEQ: branch_cond = (i_dec.rs_val == i_dec.rt_val);
		JUMP_BNE: branch_cond = (i_dec.rs_val != i_dec.rt_val);
		JUMP_BLTZ: branch_cond = i_dec.rs_val[`CPU_REG_WIDTH-1];
		JUMP_BGEZ: branch_cond = !i_dec.rs_val[`CPU_REG_WIDTH-1];
		default: branch_cond = 1'b0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!i_stall)
		begin
			alu_op_r <= i_dec.alu_op;
			store_data_r <= i_dec.rt_val;	// Only meaningful for SW
			link_pc_r <= i_pc_p0;
			case (i_dec.alu_src)
			SRC_RS_IMM:
			begin
				alu_a_r <= i_dec.rs_val;
				alu_b_r <= i_dec.imm;
			end
			SRC_PC_IMM:
			begin
				alu_a_r <= i_dec.pc_p1;	// Branch base is the delay slot address
				alu_b_r <= i_dec.imm;
			end
			default:
			begin
				alu_a_r <= i_dec.rs_val;
				alu_b_r <= i_dec.rt_val;
			end
			endcase
		end
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			rd_no_r <= '0;
			ovf_en_r <= 1'b0;
			is_jump_r <= 1'b0;
			taken_r <= 1'b0;
			link_r <= 1'b0;
			lsu_op_r <= LSU_IDLE;
			sw_trap_r <= TRAP_NONE;
		end
		else if (!i_stall)
		begin
			rd_no_r <= i_nullify ? '0 : i_dec.rd_no;
			ovf_en_r <= !i_nullify && i_dec.ovf_en;
			is_jump_r <= !i_nullify && (i_dec.jump != JUMP_NONE);
			taken_r <= !i_nullify && branch_cond;
			link_r <= !i_nullify && i_dec.link;
			lsu_op_r <= i_nullify ? LSU_IDLE : i_dec.lsu_op;
			sw_trap_r <= i_nullify ? TRAP_NONE : i_dec.sw_trap;
		end
	end

	alu u_alu (
		.i_op		(alu_op_r),
		.i_a		(alu_a_r),
		.i_b		(alu_b_r),
		.o_result	(alu_result),
		.o_ovf		(alu_ovf)
	);

	assign wb_rd_no = (is_jump_r && !taken_r) ? '0 : rd_no_r;	// Not-taken branch writes nothing

	always_comb
	begin
		o_wb.en = !i_stall && (wb_rd_no != '0);	// A stalled cycle must not repeat the write
		o_wb.rd_no = wb_rd_no;
		o_wb.data = link_r ? link_pc_r : alu_result;
		o_jump.valid = taken_r;
		o_jump.addr = alu_result;	// Jump target and memory address both come from the adder
		o_mem.op = lsu_op_r;
		o_mem.addr = alu_result;
		o_mem.data = store_data_r;
		o_exc.overflow = alu_ovf && ovf_en_r;
		o_exc.addr_error = taken_r && (alu_result[1:0] != 2'b00);
		o_exc.syscall = (sw_trap_r == TRAP_SYSCALL);
		o_exc.brk = (sw_trap_r == TRAP_BREAK);
	end

	// Decoder never marks one instruction as both a jump and a memory access
	a_jump_no_mem: assert property (@(posedge clk) disable iff (!nrst)
		o_jump.valid |-> (o_mem.op == LSU_IDLE))
		else $error("memory request issued together with a taken jump");

endmodule

// ==== list.f ====
+incdir+.
cpu_pkg.sv
alu.sv
decoder.sv
execute_stage.sv
regfile.sv
exec_slice_top.sv
tb_exec_slice.sv

// ==== regfile.sv ====
`timescale 1ns/10ps
`include "cpu_defines.svh"

module regfile
	import cpu_pkg::*;
(
	input  logic				clk,
	input  logic				nrst,
	input  logic [`CPU_REGNO_WIDTH-1:0]	i_rs_no,
	input  logic [`CPU_REGNO_WIDTH-1:0]	i_rt_no,
	input  wb_t				i_wb,
	output logic [`CPU_REG_WIDTH-1:0]	o_rs_val,
	output logic [`CPU_REG_WIDTH-1:0]	o_rt_val
);

	logic [`CPU_REG_WIDTH-1:0] regs [1:31];	// Register zero has no storage

	// One read port, with the pending writeback taking priority over storage
	function automatic logic [`CPU_REG_WIDTH-1:0] read_port(
		input logic [`CPU_REGNO_WIDTH-1:0] no
	);
		if (no == '0)
			return '0;
		else if (i_wb.en && (i_wb.rd_no == no))
			return i_wb.data;
		else
			return regs[no];
	endfunction

	always_comb
	begin
		o_rs_val = read_port(i_rs_no);
		o_rt_val = read_port(i_rt_no);
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end
		else if (i_wb.en && (i_wb.rd_no != '0))
			regs[i_wb.rd_no] <= i_wb.data;
	end

	// The execute stage is expected to fold rd zero into a disabled write
	a_no_r0_write: assert property (@(posedge clk) disable iff (!nrst)
		i_wb.en |-> (i_wb.rd_no != '0))
		else $error("writeback request targets register zero");

endmodule

// ==== tb_exec_slice.sv ====
`timescale 1ns/10ps
`include "cpu_defines.svh"

module tb_exec_slice
	import cpu_pkg::*;
();

	localparam int FIELDS = 14;	// Hex words per vector line
	localparam int NUM_VECTORS = 39;
	localparam int TIMEOUT_CYCLES = 16 + NUM_VECTORS + 20;

	logic					clk;
	logic					nrst;
	logic [31:0]				instr;
	logic [`CPU_ADDR_WIDTH-1:0]		pc_p0;
	logic [`CPU_ADDR_WIDTH-1:0]		pc_p1;
	logic					stall;
	logic					nullify;
	wb_t					wb;
	jump_t					jump;
	mem_req_t				mem;
	exc_t					exc;

	logic [31:0]	vec_mem [0:FIELDS*NUM_VECTORS-1];
	int		cur_vector = 0;	// Index shown in error lines
	int		cycle_count = 0;

	exec_slice_top i_exec_slice_top (
		.clk		(clk),
		.nrst		(nrst),
		.i_instr	(instr),
		.i_pc_p0	(pc_p0),
		.i_pc_p1	(pc_p1),
		.i_stall	(stall),
		.i_nullify	(nullify),
		.o_wb		(wb),
		.o_jump		(jump),
		.o_mem		(mem),
		.o_exc		(exc)
	);

	initial
		clk = 1'b0;
	always #2 clk = ~clk;	// 4 ns period

	// Guards against a run that never reaches the end of the vectors
	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("sim failed");
			$fatal(1, "Run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
		end
	end

	task automatic report_mismatch(input string field, input logic [31:0] got,
		input logic [31:0] exp);
		$display("Error at %0t ns: vector %0d %s is %h, expected %h",
			$time, cur_vector, field, got, exp);
		$display("sim failed");
		$fatal(1);
	endtask

	// Destination and data only matter when a write is expected
	task automatic check_wb(input wb_t got, input wb_t exp);
		if (got.en !== exp.en)
			report_mismatch("wb.en", 32'(got.en), 32'(exp.en));
		else if (exp.en && (got.rd_no !== exp.rd_no))
			report_mismatch("wb.rd_no", 32'(got.rd_no), 32'(exp.rd_no));
		else if (exp.en && (got.data !== exp.data))
			report_mismatch("wb.data", got.data, exp.data);
	endtask

	task automatic check_jump(input jump_t got, input jump_t exp);
		if (got.valid !== exp.valid)
			report_mismatch("jump.valid", 32'(got.valid), 32'(exp.valid));
		else if (exp.valid && (got.addr !== exp.addr))
			report_mismatch("jump.addr", got.addr, exp.addr);
	endtask

	task automatic check_mem(input mem_req_t got, input mem_req_t exp);
		if (got.op !== exp.op)
			report_mismatch("mem.op", 32'(got.op), 32'(exp.op));
		else if ((exp.op != LSU_IDLE) && (got.addr !== exp.addr))
			report_mismatch("mem.addr", got.addr, exp.addr);
		else if ((exp.op == LSU_STORE) && (got.data !== exp.data))	// Load data comes later
			report_mismatch("mem.data", got.data, exp.data);
	endtask

	task automatic check_exc(input exc_t got, input exc_t exp);
		if (got !== exp)
			report_mismatch("exc", {28'd0, got}, {28'd0, exp});
	endtask

	task automatic apply_vector(input int k);
		int base;
		base = k * FIELDS;
		instr = vec_mem[base];
		pc_p0 = vec_mem[base+1];
		pc_p1 = vec_mem[base+2];
		stall = vec_mem[base+3][0];
		nullify = vec_mem[base+4][0];
	endtask

	// Expected columns describe the instruction of the line before
	task automatic check_vector(input int k);
		int		base;
		wb_t		exp_wb;
		jump_t		exp_jump;
		mem_req_t	exp_mem;
		exc_t		exp_exc;
		base = k * FIELDS;
		exp_wb.en = vec_mem[base+5][0];
		exp_wb.rd_no = vec_mem[base+6][4:0];
		exp_wb.data = vec_mem[base+7];
		exp_jump.valid = vec_mem[base+8][0];
		exp_jump.addr = vec_mem[base+9];
		exp_mem.op = lsu_op_e'(vec_mem[base+10][1:0]);
		exp_mem.addr = vec_mem[base+11];
		exp_mem.data = vec_mem[base+12];
		exp_exc = vec_mem[base+13][3:0];	// Overflow, addr error, syscall, break from the top
		check_wb(wb, exp_wb);
		check_jump(jump, exp_jump);
		check_mem(mem, exp_mem);
		check_exc(exc, exp_exc);
	endtask

	initial
	begin
		nrst = 1'b0;
		instr = '0;
		pc_p0 = '0;
		pc_p1 = '0;
		stall = 1'b0;
		nullify = 1'b0;
		$readmemh("exec_vectors.txt", vec_mem);
		repeat (16) @(posedge clk);
		#1;
		nrst = 1'b1;	// First vector also checks the reset state of all outputs
		for (int k = 0; k < NUM_VECTORS; k++)
		begin
			cur_vector = k;
			apply_vector(k);
			#2;	// Sample 1 ns before the next rising edge
			check_vector(k);
			@(posedge clk);
			#1;
		end
		$display("sim passed");
		$finish;
	end

endmodule
